// ==== vx_exec_stage.f ====
vx_pkg.sv
vx_alu.sv
vx_priority_encoder.sv
vx_branch_resolve.sv
vx_execute_unit.sv
vx_exec_stage.sv
vx_exec_checker.sv
vx_exec_stage_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --timing -Wno-fatal
TOP       ?= vx_exec_stage_tb
FILELIST  ?= vx_exec_stage.f
RTL_TOP   ?= vx_exec_stage
RTL_FILES = vx_pkg.sv vx_alu.sv vx_priority_encoder.sv vx_branch_resolve.sv \
	vx_execute_unit.sv vx_exec_stage.sv

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(RTL_FILES) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) -o V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf obj_dir

// ==== vx_exec_stage_tb.sv ====
`timescale 1ns/10ps

module vx_exec_stage_tb import vx_pkg::*;;

	localparam int NT       = 4;
	localparam int ENTRIES  = 20;

	// a mode 0 keeps the raw value, 1 forces a small positive
	// b mode 0 is random, 1 equals a, 2 is a+1, 3 is a-1
	// Masked lanes get the opposite relation in b modes 1 to 3
	typedef struct packed {
		alu_op_e     op;
		logic        rs2;
		branch_e     br;
		logic        jal;
		logic [31:0] itype;
		logic [19:0] upper;
		logic [3:0]  mask;
		logic        amode;
		logic [1:0]  bmode;
	} entry_t;

	logic                    clk = 0;
	logic                    reset = 1;
	int                      tag = -1;
	exec_req_t               req;
	logic [NT-1:0]           valid;
	logic [NT-1:0][XLEN-1:0] a_data;
	logic [NT-1:0][XLEN-1:0] b_data;
	exec_wb_t                wb;
	logic [NT-1:0]           wb_valid;
	logic [NT-1:0][XLEN-1:0] wb_data;
	jal_rsp_t                jal_rsp;
	branch_rsp_t             branch_rsp;
	int                      pass_count;
	int                      fail_count;
	int                      tests_done;
	entry_t                  table_e [ENTRIES];
	logic [31:0]             rng = 32'd50;

	always #50 clk = ~clk;

	vx_exec_stage #(.NUM_THREADS(NT)) i_vx_exec_stage (
		.clk(clk), .reset(reset), .req(req), .valid(valid), .a_data(a_data),
		.b_data(b_data), .wb(wb), .wb_valid(wb_valid), .wb_data(wb_data),
		.jal_rsp(jal_rsp), .branch_rsp(branch_rsp)
	);

	vx_exec_checker #(.NUM_THREADS(NT)) i_checker (
		.clk(clk), .tag(tag), .req(req), .valid(valid), .a_data(a_data),
		.b_data(b_data), .wb(wb), .wb_valid(wb_valid), .wb_data(wb_data),
		.jal_rsp(jal_rsp), .branch_rsp(branch_rsp), .pass_count(pass_count),
		.fail_count(fail_count), .tests_done(tests_done)
	);

	function automatic logic [31:0] xorshift32(logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_rand();
		rng = xorshift32(rng);
		return rng;
	endfunction

	task automatic apply_entry(entry_t e);
		logic [31:0] a;
		req.alu_op      = e.op;
		req.rs2_src     = e.rs2;
		req.branch_type = e.br;
		req.jal         = e.jal;
		req.itype_immed = e.itype;
		req.upper_immed = e.upper;
		req.jal_offset  = next_rand();
		req.curr_pc     = next_rand() & 32'hffff_fffc;
		req.pc_next     = req.curr_pc + 4;
		req.rd          = 5'(next_rand());
		req.wb          = 2'(next_rand());
		req.warp_num    = WARP_BITS'(next_rand());
		valid           = e.mask;
		for (int i = 0; i < NT; i++)
		begin
			a = next_rand();
			if (e.amode)
				a = (a & 32'h3fff_fff0) | 32'h10;
			a_data[i] = a;
			case (e.bmode)
				2'd1:    b_data[i] = e.mask[i] ? a : a + 1;
				2'd2:    b_data[i] = e.mask[i] ? a + 1 : a - 1;
				2'd3:    b_data[i] = e.mask[i] ? a - 1 : a + 1;
				default: b_data[i] = next_rand();
			endcase
		end
	endtask

	initial
	begin
		table_e[0]  = '{ALU_ADD,   0, NO_BRANCH, 0, 32'h0,        20'h0,     4'hf, 0, 0};
		table_e[1]  = '{ALU_SUB,   0, NO_BRANCH, 0, 32'h0,        20'h0,     4'hf, 0, 0};
		table_e[2]  = '{ALU_SLL,   1, NO_BRANCH, 0, 32'h7,        20'h0,     4'hf, 0, 0};
		table_e[3]  = '{ALU_SRL,   0, NO_BRANCH, 0, 32'h0,        20'h0,     4'hf, 0, 0};
		table_e[4]  = '{ALU_SRA,   1, NO_BRANCH, 0, 32'h5,        20'h0,     4'hf, 0, 0};
		table_e[5]  = '{ALU_SLT,   0, NO_BRANCH, 0, 32'h0,        20'h0,     4'hf, 0, 0};
		table_e[6]  = '{ALU_SLTU,  1, NO_BRANCH, 0, 32'h8000_0000, 20'h0,    4'hf, 0, 0};
		table_e[7]  = '{ALU_XOR,   0, NO_BRANCH, 0, 32'h0,        20'h0,     4'hf, 0, 0};
		table_e[8]  = '{ALU_OR,    1, NO_BRANCH, 0, 32'hffff_f800, 20'h0,    4'hf, 0, 0};
		table_e[9]  = '{ALU_AND,   0, NO_BRANCH, 0, 32'h0,        20'h0,     4'hf, 0, 0};
		table_e[10] = '{ALU_LUI,   1, NO_BRANCH, 0, 32'h0,        20'habcde, 4'hf, 0, 0};
		table_e[11] = '{ALU_AUIPC, 1, NO_BRANCH, 0, 32'h0,        20'h12345, 4'hf, 0, 0};
		table_e[12] = '{ALU_SUB,   0, BEQ,       0, 32'h40,       20'h0,     4'he, 1, 1};
		table_e[13] = '{ALU_SUB,   0, BNE,       0, 32'hffff_fff0, 20'h0,    4'hc, 1, 1};
		table_e[14] = '{ALU_SLT,   0, BLT,       0, 32'h100,      20'h0,     4'he, 1, 2};
		table_e[15] = '{ALU_SLT,   0, BGE,       0, 32'h8,        20'h0,     4'h8, 1, 2};
		table_e[16] = '{ALU_SLTU,  0, BLTU,      0, 32'h20,       20'h0,     4'ha, 1, 3};
		table_e[17] = '{ALU_SLTU,  0, BGEU,      0, 32'hffff_ff00, 20'h0,    4'he, 1, 3};
		table_e[18] = '{ALU_ADD,   0, NO_BRANCH, 1, 32'h0,        20'h0,     4'h6, 0, 0};
		table_e[19] = '{ALU_ADD,   0, BEQ,       1, 32'h0,        20'h0,     4'h0, 1, 1};
	end

	// Inputs start known so the request register never takes X
	initial
	begin
		req    = '0;
		valid  = '0;
		a_data = '0;
		b_data = '0;
		repeat (4) @(posedge clk);
		#1 reset = 0;
	end

	initial
	begin : main
		int cycles;
		cycles = 0;
		while (reset && cycles < 20)
		begin
			@(posedge clk);
			cycles++;
		end
		if (reset)
		begin
			$display("Timeout waiting for reset to be released");
			$display("Result: FAILED");
			$finish;
		end
		// One idle cycle checks the cleared outputs before the first entry
		#1;
		tag = 0;
		for (int t = 0; t < ENTRIES; t++)
		begin
			@(posedge clk);
			#1;
			apply_entry(table_e[t]);
			tag = t + 1;
		end
		@(posedge clk);
		#1;
		valid = '0;
		tag = -1;
		cycles = 0;
		while (tests_done < ENTRIES + 1 && cycles < 50)
		begin
			@(posedge clk);
			cycles++;
		end
		if (tests_done < ENTRIES + 1)
		begin
			$display("Timeout, only %0d of %0d tests were checked", tests_done, ENTRIES + 1);
			$display("Result: FAILED");
		end
		else
		begin
			$display("passed %0d failed %0d", pass_count, fail_count);
			if (fail_count == 0)
				$display("Result: PASSED");
			else
				$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// ==== vx_exec_checker.sv ====
`timescale 1ns/10ps

module vx_exec_checker import vx_pkg::*; #(
	parameter int NUM_THREADS = 4
)(
	input  logic                             clk,
	input  int                               tag,
	input  exec_req_t                        req,
	input  logic [NUM_THREADS-1:0]           valid,
	input  logic [NUM_THREADS-1:0][XLEN-1:0] a_data,
	input  logic [NUM_THREADS-1:0][XLEN-1:0] b_data,
	input  exec_wb_t                         wb,
	input  logic [NUM_THREADS-1:0]           wb_valid,
	input  logic [NUM_THREADS-1:0][XLEN-1:0] wb_data,
	input  jal_rsp_t                         jal_rsp,
	input  branch_rsp_t                      branch_rsp,
	output int                               pass_count,
	output int                               fail_count,
	output int                               tests_done
);

	int                               tag_s = -1;
	exec_req_t                        req_s;
	logic [NUM_THREADS-1:0]           valid_s;
	logic [NUM_THREADS-1:0][XLEN-1:0] a_s;
	logic [NUM_THREADS-1:0][XLEN-1:0] b_s;

	initial
	begin
		pass_count = 0;
		fail_count = 0;
		tests_done = 0;
	end

	// Reference ALU written from the opcode rules
	function automatic logic [31:0] model_alu(alu_op_e op, logic [31:0] a, logic [31:0] b,
		logic [31:0] pc, logic [19:0] up);
		logic [31:0] upv;
		upv = {up, 12'h000};
		case (op)
			ALU_ADD:   return a + b;
			ALU_SUB:   return a - b;
			ALU_SLL:   return a << b[4:0];
			ALU_SRL:   return a >> b[4:0];
			ALU_SRA:   return $unsigned($signed(a) >>> b[4:0]);
			ALU_SLT:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			ALU_SLTU:  return (a < b) ? 32'd1 : 32'd0;
			ALU_XOR:   return a ^ b;
			ALU_OR:    return a | b;
			ALU_AND:   return a & b;
			ALU_LUI:   return upv;
			ALU_AUIPC: return pc + upv;
			default:   return 32'h0;
		endcase
	endfunction

	// Capture what the DUT register takes at this edge
	always @(posedge clk)
	begin
		tag_s   <= tag;
		req_s   <= req;
		valid_s <= valid;
		a_s     <= a_data;
		b_s     <= b_data;
	end

	// Outputs are settled by the falling edge
	always @(negedge clk)
	begin : compare
		int          errs;
		int          low;
		logic [31:0] res;
		logic [31:0] exp_data;
		logic [31:0] sel_res;
		logic        exp_dir;
		logic        any;
		exec_wb_t    exp_wb;
		if (tag_s >= 0)
		begin
			errs    = 0;
			any     = |valid_s;
			low     = 0;
			sel_res = 0;
			for (int i = NUM_THREADS - 1; i >= 0; i--)
			begin
				if (valid_s[i])
					low = i;
			end
			if (wb_valid !== valid_s)
			begin
				$display("MISMATCH wb_valid expected %h got %h", valid_s, wb_valid);
				errs++;
			end
			if (jal_rsp.jal !== (req_s.jal && any))
			begin
				$display("MISMATCH jal_rsp.jal expected %h got %h", req_s.jal && any, jal_rsp.jal);
				errs++;
			end
			if (branch_rsp.valid_branch !== ((req_s.branch_type != NO_BRANCH) && any))
			begin
				$display("MISMATCH valid_branch expected %h got %h",
					(req_s.branch_type != NO_BRANCH) && any, branch_rsp.valid_branch);
				errs++;
			end
			if (tag_s > 0)
			begin
				for (int i = 0; i < NUM_THREADS; i++)
				begin
					res = model_alu(req_s.alu_op, a_s[i], req_s.rs2_src ? req_s.itype_immed : b_s[i],
						req_s.curr_pc, req_s.upper_immed);
					if (i == low)
						sel_res = res;
					exp_data = req_s.jal ? req_s.pc_next : res;
					if (wb_data[i] !== exp_data)
					begin
						$display("MISMATCH wb_data[%0d] expected %h got %h", i, exp_data, wb_data[i]);
						errs++;
					end
				end
				exp_wb.rd       = req_s.rd;
				exp_wb.wb       = req_s.wb;
				exp_wb.warp_num = req_s.warp_num;
				exp_wb.pc       = req_s.curr_pc;
				if (wb !== exp_wb)
				begin
					$display("MISMATCH wb expected %h got %h", exp_wb, wb);
					errs++;
				end
				case (req_s.branch_type)
					BEQ:        exp_dir = (sel_res == 0);
					BNE:        exp_dir = (sel_res != 0);
					BLT, BLTU:  exp_dir = sel_res[0];
					BGE, BGEU:  exp_dir = !sel_res[0];
					default:    exp_dir = 1'b0;
				endcase
				if (any && branch_rsp.branch_dir !== exp_dir)
				begin
					$display("MISMATCH branch_dir expected %h got %h", exp_dir, branch_rsp.branch_dir);
					errs++;
				end
				if (branch_rsp.branch_dest !== req_s.curr_pc + (req_s.itype_immed << 1))
				begin
					$display("MISMATCH branch_dest expected %h got %h",
						req_s.curr_pc + (req_s.itype_immed << 1), branch_rsp.branch_dest);
					errs++;
				end
				if (branch_rsp.branch_warp_num !== req_s.warp_num)
				begin
					$display("MISMATCH branch_warp_num expected %h got %h",
						req_s.warp_num, branch_rsp.branch_warp_num);
					errs++;
				end
				if (any && jal_rsp.jal_dest !== a_s[low] + req_s.jal_offset)
				begin
					$display("MISMATCH jal_dest expected %h got %h",
						a_s[low] + req_s.jal_offset, jal_rsp.jal_dest);
					errs++;
				end
				if (jal_rsp.jal_warp_num !== req_s.warp_num)
				begin
					$display("MISMATCH jal_warp_num expected %h got %h",
						req_s.warp_num, jal_rsp.jal_warp_num);
					errs++;
				end
			end
			if (errs == 0)
			begin
				$display("test %0d passed", tag_s);
				pass_count++;
			end
			else
			begin
				$display("test %0d failed with %0d errors", tag_s, errs);
				fail_count++;
			end
			tests_done++;
		end
	end

endmodule

// ==== vx_exec_stage.sv ====
`timescale 1ns/10ps

module vx_exec_stage import vx_pkg::*; #(
	parameter int NUM_THREADS = 4
)(
	input  logic                             clk,
	input  logic                             reset,
	input  exec_req_t                        req,
	input  logic [NUM_THREADS-1:0]           valid,
	input  logic [NUM_THREADS-1:0][XLEN-1:0] a_data,
	input  logic [NUM_THREADS-1:0][XLEN-1:0] b_data,
	output exec_wb_t                         wb,
	output logic [NUM_THREADS-1:0]           wb_valid,
	output logic [NUM_THREADS-1:0][XLEN-1:0] wb_data,
	output jal_rsp_t                         jal_rsp,
	output branch_rsp_t                      branch_rsp
);

	exec_req_t                        req_q;
	logic [NUM_THREADS-1:0]           valid_q;
	logic [NUM_THREADS-1:0][XLEN-1:0] a_data_q;
	logic [NUM_THREADS-1:0][XLEN-1:0] b_data_q;

	// Lane valids gate every response
	always_ff @(posedge clk)
	begin
		if (reset)
			valid_q <= '0;
		else
			valid_q <= valid;
	end

	// Instruction fields and operands are taken every cycle
	always_ff @(posedge clk)
	begin
		req_q    <= req;
		a_data_q <= a_data;
		b_data_q <= b_data;
	end

	vx_execute_unit #(
		.NUM_THREADS (NUM_THREADS)
	) i_vx_execute_unit (
		.req        (req_q),
		.valid      (valid_q),
		.a_data     (a_data_q),
		.b_data     (b_data_q),
		.wb         (wb),
		.wb_valid   (wb_valid),
		.wb_data    (wb_data),
		.jal_rsp    (jal_rsp),
		.branch_rsp (branch_rsp)
	);

endmodule

// ==== vx_execute_unit.sv ====
`timescale 1ns/10ps

module vx_execute_unit import vx_pkg::*; #(
	parameter int NUM_THREADS = 4
)(
	input  exec_req_t                        req,
	input  logic [NUM_THREADS-1:0]           valid,
	input  logic [NUM_THREADS-1:0][XLEN-1:0] a_data,
	input  logic [NUM_THREADS-1:0][XLEN-1:0] b_data,
	output exec_wb_t                         wb,
	output logic [NUM_THREADS-1:0]           wb_valid,
	output logic [NUM_THREADS-1:0][XLEN-1:0] wb_data,
	output jal_rsp_t                         jal_rsp,
	output branch_rsp_t                      branch_rsp
);

	localparam int IDX_W = (NUM_THREADS > 1) ? $clog2(NUM_THREADS) : 1;

	logic [NUM_THREADS-1:0][XLEN-1:0] alu_result;
	logic [IDX_W-1:0]                 lane_index;
	logic                             lane_found;
	logic                             branch_dir;
	logic [XLEN-1:0]                  branch_dest;

	// One ALU per thread lane
	for (genvar lane = 0; lane < NUM_THREADS; lane++)
	begin : g_lane
		vx_alu i_vx_alu (
			.in_1        (a_data[lane]),
			.in_2        (b_data[lane]),
			.rs2_src     (req.rs2_src),
			.itype_immed (req.itype_immed),
			.upper_immed (req.upper_immed),
			.alu_op      (req.alu_op),
			.curr_pc     (req.curr_pc),
			.result      (alu_result[lane])
		);
	end

	// Lowest active lane decides branch and jump
	vx_priority_encoder #(
		.N (NUM_THREADS)
	) i_vx_priority_encoder (
		.valids (valid),
		.index  (lane_index),
		.found  (lane_found)
	);

	vx_branch_resolve i_vx_branch_resolve (
		.branch_type   (req.branch_type),
		.alu_result    (alu_result[lane_index]),
		.curr_pc       (req.curr_pc),
		.branch_offset (req.itype_immed),
		.branch_dir    (branch_dir),
		.branch_dest   (branch_dest)
	);

	// Link instructions write the return PC to every lane
	always_comb
	begin
		for (int i = 0; i < NUM_THREADS; i++)
		begin
			wb_data[i] = req.jal ? req.pc_next : alu_result[i];
		end
	end

	assign wb_valid = valid;
	assign wb       = '{rd: req.rd, wb: req.wb, warp_num: req.warp_num, pc: req.curr_pc};

	assign jal_rsp.jal          = req.jal && lane_found;
	assign jal_rsp.jal_dest     = a_data[lane_index] + req.jal_offset;
	assign jal_rsp.jal_warp_num = req.warp_num;

	assign branch_rsp.valid_branch    = (req.branch_type != NO_BRANCH) && lane_found;
	assign branch_rsp.branch_dir      = branch_dir;
	assign branch_rsp.branch_dest     = branch_dest;
	assign branch_rsp.branch_warp_num = req.warp_num;

endmodule

// ==== vx_branch_resolve.sv ====
`timescale 1ns/10ps

module vx_branch_resolve import vx_pkg::*; (
	input  branch_e         branch_type,
	input  logic [XLEN-1:0] alu_result,
	input  logic [XLEN-1:0] curr_pc,
	input  logic [31:0]     branch_offset,
	output logic            branch_dir,
	output logic [XLEN-1:0] branch_dest
);

	logic result_zero;

	// BEQ/BNE come in as a subtract, the rest as SLT or SLTU
	assign result_zero = (alu_result == '0);

	always_comb
	begin
		case (branch_type)
			BEQ:
			begin
				branch_dir = result_zero;
			end
			BNE:
			begin
				branch_dir = !result_zero;
			end
			BLT, BLTU:
			begin
				branch_dir = alu_result[0];
			end
			BGE, BGEU:
			begin
				branch_dir = !alu_result[0];
			end
			default:
			begin
				branch_dir = 1'b0;
			end
		endcase
	end

	// Offset counts halfwords
	assign branch_dest = curr_pc + (branch_offset << 1);

endmodule

// ==== vx_priority_encoder.sv ====
`timescale 1ns/10ps

module vx_priority_encoder #(
	parameter int  N     = 4,
	localparam int IDX_W = (N > 1) ? $clog2(N) : 1
)(
	input  logic [N-1:0]     valids,
	output logic [IDX_W-1:0] index,
	output logic             found
);

	// Walk downwards so the lowest set bit is written last
	always_comb
	begin
		index = '0;
		for (int i = N - 1; i >= 0; i--)
		begin
			if (valids[i])
			begin
				index = IDX_W'(i);
			end
		end
	end

	assign found = |valids;

endmodule

// ==== vx_alu.sv ====
`timescale 1ns/10ps

module vx_alu import vx_pkg::*; (
	input  logic [XLEN-1:0] in_1,
	input  logic [XLEN-1:0] in_2,
	input  logic            rs2_src,
	input  logic [31:0]     itype_immed,
	input  logic [19:0]     upper_immed,
	input  alu_op_e         alu_op,
	input  logic [XLEN-1:0] curr_pc,
	output logic [XLEN-1:0] result
);

	logic [XLEN-1:0] operand_b;
	logic [4:0]      shamt;
	logic [XLEN-1:0] upper_value;

	// Immediate replaces rs2 for I-type forms
	assign operand_b = rs2_src ? itype_immed : in_2;
	assign shamt     = operand_b[4:0];

	// LUI payload sits in the top 20 bits
	assign upper_value = {upper_immed, 12'b0};

	always_comb
	begin
		case (alu_op)
			ALU_ADD:
			begin
				result = in_1 + operand_b;
			end
			ALU_SUB:
			begin
				result = in_1 - operand_b;
			end
			ALU_SLL:
			begin
				result = in_1 << shamt;
			end
			ALU_SRL:
			begin
				result = in_1 >> shamt;
			end
			ALU_SRA:
			begin
				result = $signed(in_1) >>> shamt;
			end
			ALU_SLT:
			begin
				result = ($signed(in_1) < $signed(operand_b)) ? XLEN'(1) : '0;
			end
			ALU_SLTU:
			begin
				result = (in_1 < operand_b) ? XLEN'(1) : '0;
			end
			ALU_XOR:
			begin
				result = in_1 ^ operand_b;
			end
			ALU_OR:
			begin
				result = in_1 | operand_b;
			end
			ALU_AND:
			begin
				result = in_1 & operand_b;
			end
			ALU_LUI:
			begin
				result = upper_value;
			end
			ALU_AUIPC:
			begin
				result = curr_pc + upper_value;
			end
			default:
			begin
				result = '0;
			end
		endcase
	end

endmodule

// ==== vx_pkg.sv ====
package vx_pkg;

	// Data word and warp id widths
	localparam int XLEN      = 32;
	localparam int WARP_BITS = 2;

	// ALU operations issued by decode
	typedef enum logic [4:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_OR,
		ALU_AND,
		ALU_LUI,
		ALU_AUIPC
	} alu_op_e;

	// Conditional branch kinds
	typedef enum logic [2:0] {
		NO_BRANCH,
		BEQ,
		BNE,
		BLT,
		BGE,
		BLTU,
		BGEU
	} branch_e;

	// Scalar fields of one warp instruction
	typedef struct packed {
		alu_op_e              alu_op;
		logic                 rs2_src;
		logic [31:0]          itype_immed;
		branch_e              branch_type;
		logic [19:0]          upper_immed;
		logic                 jal;
		logic [31:0]          jal_offset;
		logic [XLEN-1:0]      curr_pc;
		logic [XLEN-1:0]      pc_next;
		logic [4:0]           rd;
		logic [1:0]           wb;
		logic [WARP_BITS-1:0] warp_num;
	} exec_req_t;

	// Writeback header without the lane data
	typedef struct packed {
		logic [4:0]           rd;
		logic [1:0]           wb;
		logic [WARP_BITS-1:0] warp_num;
		logic [XLEN-1:0]      pc;
	} exec_wb_t;

	typedef struct packed {
		logic                 jal;
		logic [XLEN-1:0]      jal_dest;
		logic [WARP_BITS-1:0] jal_warp_num;
	} jal_rsp_t;

	typedef struct packed {
		logic                 valid_branch;
		logic                 branch_dir;
		logic [XLEN-1:0]      branch_dest;
		logic [WARP_BITS-1:0] branch_warp_num;
	} branch_rsp_t;

endpackage
